// ==== include/dma_init_params.svh ====
`ifndef DMA_INIT_PARAMS_SVH
`define DMA_INIT_PARAMS_SVH

// Bus and datapath widths
`define DATA_W        32
`define CE_W          32
`define REG_IDX_W     5

// Buffer queue
`define Q_DEPTH       32
`define Q_LVL_W       6

// Region of one buffer and its interrupt length
`define REGION_BYTES  32'h0040_0000
`define IRQ_4M_CYCLES 64

// Register indices
`define REG_LEN       5'd0
`define REG_ADDR      5'd1
`define REG_PER       5'd2
`define REG_LVL       5'd3
`define REG_SEG       5'd4

// DMA command table, six writes per sequence
`define N_CMDS        6
`define CMD1_ADDR     32'h7900_000C
`define CMD2_ADDR     32'h4040_0030
`define CMD3_ADDR     32'h4040_0034
`define CMD4_ADDR     32'h4040_0048
`define CMD5_ADDR     32'h4040_0058
`define CMD6_ADDR     32'h7900_000C
`define CMD2_DATA     32'h0000_1001
`define CMD3_DATA     32'h0000_1000
`define CMD5_DATA     32'hFFFF_FFFF
`define CMD6_BASE     32'h0001_0000

`endif

// ==== verilog/dma_init_pkg.sv ====
`default_nettype none
`include "dma_init_params.svh"

package dma_init_pkg;

  // Chip-enable register bus, processor side
  typedef struct packed {
    logic [`CE_W-1:0]   rd_ce;   // One-hot, MSB is register 0
    logic [`CE_W-1:0]   wr_ce;   // Same layout as rd_ce
    logic [`DATA_W-1:0] data;
  } bus_req_t;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic               rd_ack;
    logic               wr_ack;
    logic               error;
  } bus_rsp_t;

  // Record length in words and strobe period in cycles
  typedef struct packed {
    logic [`DATA_W-1:0] len;
    logic [`DATA_W-1:0] period;
  } dma_cfg_t;

  // AXI4-Lite write channels towards the DMA engine
  typedef struct packed {
    logic [`DATA_W-1:0]   awaddr;
    logic                 awvalid;
    logic [`DATA_W-1:0]   wdata;
    logic [`DATA_W/8-1:0] wstrb;
    logic                 wvalid;
    logic                 bready;
  } axil_wr_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
  } axil_wr_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/reg_bank.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_init_params.svh"

module reg_bank import dma_init_pkg::*; (
  input  wire                 M_AXI_ACLK,
  input  wire                 M_AXI_ARESETN,
  input  wire bus_req_t       bus_req,
  output bus_rsp_t            bus_rsp,
  input  wire [`DATA_W-1:0]   cur_addr,
  input  wire [`Q_LVL_W-1:0]  level,
  input  wire [`DATA_W-1:0]   seg,
  output dma_cfg_t            cfg,
  output logic                push,
  output logic [`DATA_W-1:0]  push_data
);

  logic [`CE_W-1:0]      ce_any;
  logic                  sel;
  logic                  sel_d;
  logic                  sel_2d;
  logic                  rwn;
  logic [`REG_IDX_W-1:0] idx;
  logic [`DATA_W-1:0]    wdata;
  logic [`DATA_W-1:0]    rdata;
  logic [`DATA_W-1:0]    rsp_data;
  logic                  rd_ack;
  logic                  wr_ack;
  logic                  wr_stb;
  logic                  ack_s;
  logic [`DATA_W-1:0]    len;
  logic [`DATA_W-1:0]    period;

  // One-hot CE to register index, MSB first
  function automatic logic [`REG_IDX_W-1:0] ce_to_idx(input logic [`CE_W-1:0] ce);
    logic [`REG_IDX_W-1:0] r;
    r = '1;
    for (int i = 0; i < `CE_W; i++) begin
      if (ce[i]) r = `REG_IDX_W'(`CE_W - 1 - i);
    end
    return r;
  endfunction

  assign ce_any = (bus_req.rd_ce != '0) ? bus_req.rd_ce : bus_req.wr_ce;
  assign wr_stb = sel && !sel_d && !rwn;   // First cycle of a select only
  assign ack_s  = sel_d && !sel_2d;

  //////////////////////////////////////////////////////////////////////
  // Bus front end

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      sel    <= 1'b0;
      rwn    <= 1'b0;
      sel_d  <= 1'b0;
      sel_2d <= 1'b0;
      rd_ack <= 1'b0;
      wr_ack <= 1'b0;
    end else begin
      sel    <= (ce_any != '0);
      rwn    <= (bus_req.rd_ce != '0);
      sel_d  <= sel;
      sel_2d <= sel_d;
      rd_ack <= ack_s && rwn;
      wr_ack <= ack_s && !rwn;
    end
  end

  always_ff @(posedge M_AXI_ACLK) begin
    idx      <= ce_to_idx(ce_any);
    wdata    <= bus_req.data;
    rsp_data <= rdata;   // Lines up with the ack
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration and read-back

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      len    <= '0;
      period <= '0;
    end else if (wr_stb) begin
      if (idx == `REG_LEN) len <= wdata;
      if (idx == `REG_PER) period <= wdata;
    end
  end

  always_ff @(posedge M_AXI_ACLK) begin
    case (idx)
      `REG_LEN:  rdata <= len;
      `REG_ADDR: rdata <= cur_addr;   // Buffer in use, not the last written
      `REG_PER:  rdata <= period;
      `REG_LVL:  rdata <= `DATA_W'(level);
      `REG_SEG:  rdata <= seg;
      default:   rdata <= '0;
    endcase
  end

  assign push      = wr_stb && (idx == `REG_ADDR);
  assign push_data = wdata;

  assign cfg     = '{len: len, period: period};
  assign bus_rsp = '{data: rsp_data, rd_ack: rd_ack, wr_ack: wr_ack, error: 1'b0};

  // Host selects at most one register, read or write
  a_ce_onehot: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    $onehot0({bus_req.rd_ce, bus_req.wr_ce}));

endmodule

`default_nettype wire

// ==== verilog/addr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_init_params.svh"

module addr_queue (
  input  wire                 M_AXI_ACLK,
  input  wire                 M_AXI_ARESETN,
  input  wire                 push,
  input  wire [`DATA_W-1:0]   push_data,
  input  wire                 pop,
  output logic [`DATA_W-1:0]  cur_addr,
  output logic [`Q_LVL_W-1:0] level
);

  localparam int PTR_W = $clog2(`Q_DEPTH);

  logic [`DATA_W-1:0] q [`Q_DEPTH];
  logic               full;
  logic               empty;
  logic               pop_ok;
  logic               push_ok;
  logic [PTR_W-1:0]   wr_ptr;

  assign full    = (level == `Q_LVL_W'(`Q_DEPTH));
  assign empty   = (level == '0);
  assign pop_ok  = pop && !empty;
  assign push_ok = push && (!full || pop_ok);   // Pop frees a slot this cycle
  // First free slot once the shift is done
  assign wr_ptr  = pop_ok ? PTR_W'(level - 1'b1) : PTR_W'(level);

  // Shift storage, head at q[0]
  always_ff @(posedge M_AXI_ACLK) begin
    if (pop_ok) begin
      for (int i = 0; i < `Q_DEPTH - 1; i++) begin
        q[i] <= q[i + 1];
      end
      q[`Q_DEPTH-1] <= '0;
    end
    if (push_ok) begin
      q[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      cur_addr <= '0;
      level    <= '0;
    end else begin
      if (pop) begin
        cur_addr <= empty ? '0 : q[0];   // No buffer left
      end
      case ({push_ok, pop_ok})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    push |-> (!full || pop));

endmodule

`default_nettype wire

// ==== verilog/segment_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_init_params.svh"

module segment_tracker import dma_init_pkg::*; (
  input  wire                 M_AXI_ACLK,
  input  wire                 M_AXI_ARESETN,
  input  wire                 irq_dma,
  input  wire dma_cfg_t       cfg,
  input  wire [`DATA_W-1:0]   cur_addr,
  input  wire [`Q_LVL_W-1:0]  level,
  output logic [`DATA_W-1:0]  seg,
  output logic                seg_done,
  output logic                pop,
  output logic                irq_4m
);

  localparam int CNT_W  = $clog2(`IRQ_4M_CYCLES);
  localparam int SPAN_W = 2 * `DATA_W;

  logic              irq_ff;
  logic              irq_ff2;
  logic [SPAN_W-1:0] span;
  logic              region_end;
  logic              pop_d;
  logic              irq_start;
  logic [CNT_W-1:0]  irq_cnt;

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      irq_ff  <= 1'b0;
      irq_ff2 <= 1'b0;
    end else begin
      irq_ff  <= irq_dma;
      irq_ff2 <= irq_ff;
    end
  end

  assign seg_done = irq_ff && !irq_ff2;

  // Bytes up to the end of the segment after the incremented one
  assign span       = (SPAN_W'(cfg.len) << 2) * (SPAN_W'(seg) + SPAN_W'(2));
  assign region_end = (span > SPAN_W'(`REGION_BYTES));

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      seg <= '0;
      pop <= 1'b0;
    end else begin
      pop <= 1'b0;
      if (seg_done) begin
        if (region_end) begin
          seg <= '0;     // Region full
          pop <= 1'b1;
        end else begin
          seg <= seg + 1'b1;
        end
      end else if ((cur_addr == '0) && (level != '0) && !pop) begin
        pop <= 1'b1;     // No buffer yet, take the first queued one
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Region interrupt

  assign irq_start = pop_d && (cur_addr != '0);
  assign irq_4m    = irq_start || (irq_cnt != '0);

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      pop_d   <= 1'b0;
      irq_cnt <= '0;
    end else begin
      pop_d <= pop;
      if (irq_start) begin
        irq_cnt <= CNT_W'(`IRQ_4M_CYCLES - 1);   // First cycle already out
      end else if (irq_cnt != '0) begin
        irq_cnt <= irq_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/dma_programmer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_init_params.svh"

module dma_programmer import dma_init_pkg::*; (
  input  wire                M_AXI_ACLK,
  input  wire                M_AXI_ARESETN,
  input  wire dma_cfg_t      cfg,
  input  wire [`DATA_W-1:0]  cur_addr,
  input  wire [`DATA_W-1:0]  seg,
  input  wire                seg_done,
  output axil_wr_req_t       m_axi_wr,
  input  wire axil_wr_rsp_t  m_axi_wr_rsp,
  output logic               str_lsr
);

  localparam int CMD_W = $clog2(`N_CMDS);

  logic [`DATA_W-1:0] per_cnt;
  logic [`DATA_W-1:0] per_last;
  logic               per_en;
  logic               busy;
  logic               start;
  logic               cmd_done;
  logic [CMD_W-1:0]   cmd_idx;
  logic               awvalid;
  logic               wvalid;
  logic [`DATA_W-1:0] awaddr;
  logic [`DATA_W-1:0] wdata;

  //////////////////////////////////////////////////////////////////////
  // Period strobe

  assign per_en   = (cfg.period != '0) && (cfg.period >= cfg.len);
  assign per_last = cfg.period + 1'b1;
  assign str_lsr  = per_en && (per_cnt == per_last);

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      per_cnt <= '0;
    end else if (per_en) begin
      per_cnt <= (per_cnt >= per_last) ? '0 : per_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Command sequencer

  assign start = str_lsr && (cfg.len != '0) && !cfg.len[0] && (cur_addr != '0) && !busy;
  // Both channels accepted and the response is in
  assign cmd_done = busy && !awvalid && !wvalid && m_axi_wr_rsp.bvalid;

  always_ff @(posedge M_AXI_ACLK) begin
    if (!M_AXI_ARESETN) begin
      busy    <= 1'b0;
      cmd_idx <= '0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else if (seg_done) begin
      busy    <= 1'b0;   // DMA finished a segment, abort
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
    end else begin
      if (awvalid && m_axi_wr_rsp.awready) awvalid <= 1'b0;
      if (wvalid && m_axi_wr_rsp.wready) wvalid <= 1'b0;
      if (start) begin
        busy    <= 1'b1;
        cmd_idx <= '0;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else if (cmd_done) begin
        if (cmd_idx == CMD_W'(`N_CMDS - 1)) begin
          busy <= 1'b0;
        end else begin
          cmd_idx <= cmd_idx + 1'b1;
          awvalid <= 1'b1;
          wvalid  <= 1'b1;
        end
      end
    end
  end

  // Address and data per command
  always_comb begin
    awaddr = '0;
    wdata  = '0;
    case (cmd_idx)
      0: awaddr = `CMD1_ADDR;
      1: begin
        awaddr = `CMD2_ADDR;
        wdata  = `CMD2_DATA;
      end
      2: begin
        awaddr = `CMD3_ADDR;
        wdata  = `CMD3_DATA;
      end
      3: begin
        awaddr = `CMD4_ADDR;
        wdata  = cur_addr + ((cfg.len << 2) * seg);   // Start of current segment
      end
      4: begin
        awaddr = `CMD5_ADDR;
        wdata  = `CMD5_DATA;
      end
      5: begin
        awaddr = `CMD6_ADDR;
        wdata  = (cfg.len >> 1) - 1'b1 + `CMD6_BASE;   // Length in 64-bit beats
      end
      default: ;
    endcase
  end

  assign m_axi_wr = '{awaddr:  awaddr,
                      awvalid: awvalid,
                      wdata:   wdata,
                      wstrb:   {(`DATA_W/8){1'b1}},
                      wvalid:  wvalid,
                      bready:  1'b1};

  // Write data held steady until the DMA engine takes it
  a_w_hold: assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
    wvalid && !m_axi_wr_rsp.wready && !seg_done |=> wvalid && $stable(wdata));

endmodule

`default_nettype wire

// ==== verilog/dma_init_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_init_params.svh"

module dma_init_top import dma_init_pkg::*; (
  input  wire               M_AXI_ACLK,
  input  wire               M_AXI_ARESETN,
  input  wire bus_req_t     bus_req,
  output bus_rsp_t          bus_rsp,
  output axil_wr_req_t      m_axi_wr,
  input  wire axil_wr_rsp_t m_axi_wr_rsp,
  input  wire               irq_dma,
  output logic              irq_4m,
  output logic              str_lsr
);

  dma_cfg_t            cfg;
  logic                push;
  logic [`DATA_W-1:0]  push_data;
  logic                pop;
  logic [`DATA_W-1:0]  cur_addr;
  logic [`Q_LVL_W-1:0] level;
  logic [`DATA_W-1:0]  seg;
  logic                seg_done;

  reg_bank i_reg_bank (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .bus_req       (bus_req),
    .bus_rsp       (bus_rsp),
    .cur_addr      (cur_addr),
    .level         (level),
    .seg           (seg),
    .cfg           (cfg),
    .push          (push),
    .push_data     (push_data)
  );

  addr_queue i_addr_queue (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .push          (push),
    .push_data     (push_data),
    .pop           (pop),
    .cur_addr      (cur_addr),
    .level         (level)
  );

  segment_tracker i_segment_tracker (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .irq_dma       (irq_dma),
    .cfg           (cfg),
    .cur_addr      (cur_addr),
    .level         (level),
    .seg           (seg),
    .seg_done      (seg_done),
    .pop           (pop),
    .irq_4m        (irq_4m)
  );

  dma_programmer i_dma_programmer (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .cfg           (cfg),
    .cur_addr      (cur_addr),
    .seg           (seg),
    .seg_done      (seg_done),
    .m_axi_wr      (m_axi_wr),
    .m_axi_wr_rsp  (m_axi_wr_rsp),
    .str_lsr       (str_lsr)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS    = 10,
  parameter int RST_CYCLES = 8
) (
  output logic M_AXI_ACLK,
  output logic M_AXI_ARESETN
);

  initial begin
    M_AXI_ACLK = 1'b0;
    forever #(HALF_NS) M_AXI_ACLK = ~M_AXI_ACLK;
  end

  // Reset released just after an edge, like any other input
  initial begin
    M_AXI_ARESETN = 1'b0;
    repeat (RST_CYCLES) @(posedge M_AXI_ACLK);
    #1;
    M_AXI_ARESETN = 1'b1;
  end

endmodule

`default_nettype wire

// ==== testbench/tb_dma_init.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "dma_init_params.svh"

module tb_dma_init import dma_init_pkg::*; ();

  localparam int          MAX_LINES = 64;
  localparam logic [31:0] OP_WRITE  = 32'h1;
  localparam logic [31:0] OP_READ   = 32'h2;
  localparam logic [31:0] OP_IRQ    = 32'h3;
  localparam logic [31:0] OP_SEQ    = 32'h4;
  localparam logic [31:0] OP_IRQ4M  = 32'h5;

  logic         M_AXI_ACLK;
  logic         M_AXI_ARESETN;
  bus_req_t     bus_req;
  bus_rsp_t     bus_rsp;
  axil_wr_req_t m_axi_wr;
  axil_wr_rsp_t m_axi_wr_rsp;
  logic         irq_dma;
  logic         irq_4m;
  logic         str_lsr;

  logic [31:0]  tv [0:4*MAX_LINES-1];   // Four words per test line
  int           n_lines;
  int           run_cycles;
  integer       seed;
  logic [31:0]  cur_len;                // Last len written
  axil_wr_req_t cmd_log [$];            // Commands taken by the responder

  tb_clock #(.HALF_NS(10), .RST_CYCLES(8)) i_tb_clock (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN)
  );

  dma_init_top i_dma_init_top (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .bus_req       (bus_req),
    .bus_rsp       (bus_rsp),
    .m_axi_wr      (m_axi_wr),
    .m_axi_wr_rsp  (m_axi_wr_rsp),
    .irq_dma       (irq_dma),
    .irq_4m        (irq_4m),
    .str_lsr       (str_lsr)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bus_data(input int idx, input bus_rsp_t got,
                                input logic [`DATA_W-1:0] exp);
    if (got.data !== exp) begin
      $display("Error: bus_rsp.data of register %0d is %h, expected %h",
               idx, got.data, exp);
      abort_run();
    end
  endtask

  task automatic check_axi_cmd(input int n, input axil_wr_req_t got,
                               input axil_wr_req_t exp);
    if ((got.awaddr !== exp.awaddr) || (got.wdata !== exp.wdata) ||
        (got.wstrb !== exp.wstrb)) begin
      $display("Error: command %0d awaddr/wdata/wstrb is %h/%h/%h, expected %h/%h/%h",
               n, got.awaddr, got.wdata, got.wstrb, exp.awaddr, exp.wdata, exp.wstrb);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks, all entered and left 1 ns after a rising edge

  task automatic bus_access(input logic is_read, input int idx,
                            input logic [`DATA_W-1:0] data, output bus_rsp_t rsp);
    logic [`CE_W-1:0] ce;
    ce = `CE_W'(1) << (`CE_W - 1 - idx);   // Register 0 on the MSB
    if (is_read) begin
      bus_req.rd_ce = ce;
    end else begin
      bus_req.wr_ce = ce;
    end
    bus_req.data = data;
    do begin
      @(posedge M_AXI_ACLK);
      #1;
    end while (!(bus_rsp.rd_ack || bus_rsp.wr_ack));
    rsp = bus_rsp;
    check_level("bus_rsp.rd_ack", rsp.rd_ack, is_read);
    check_level("bus_rsp.wr_ack", rsp.wr_ack, !is_read);
    check_level("bus_rsp.error", rsp.error, 1'b0);
    bus_req = '0;
    @(posedge M_AXI_ACLK);   // Idle cycle between accesses
    #1;
  endtask

  task automatic pulse_irq(input int count);
    repeat (count) begin
      repeat (2) begin
        @(posedge M_AXI_ACLK);
        #1;
      end
      irq_dma = 1'b1;
      @(posedge M_AXI_ACLK);
      #1;
      irq_dma = 1'b0;
    end
  endtask

  // Six writes of the next sequence against the command table
  task automatic check_sequence(input logic [`DATA_W-1:0] exp_cmd4);
    logic [`DATA_W-1:0] exp_addr [`N_CMDS];
    logic [`DATA_W-1:0] exp_data [`N_CMDS];
    axil_wr_req_t       exp;
    exp_addr = '{`CMD1_ADDR, `CMD2_ADDR, `CMD3_ADDR, `CMD4_ADDR, `CMD5_ADDR, `CMD6_ADDR};
    exp_data = '{32'h0, `CMD2_DATA, `CMD3_DATA, exp_cmd4, `CMD5_DATA,
                 cur_len / 32'd2 - 32'd1 + `CMD6_BASE};
    do begin
      @(posedge M_AXI_ACLK);
      #1;
    end while (!str_lsr);
    cmd_log.delete();   // Sequence starts at the next edge
    while (cmd_log.size() < `N_CMDS) begin
      @(posedge M_AXI_ACLK);
      #1;
    end
    for (int i = 0; i < `N_CMDS; i++) begin
      exp        = '0;
      exp.awaddr = exp_addr[i];
      exp.wdata  = exp_data[i];
      exp.wstrb  = '1;
      check_axi_cmd(i + 1, cmd_log[i], exp);
    end
  endtask

  task automatic count_irq4m(input int exp_len);
    while (irq_4m !== 1'b1) begin
      @(posedge M_AXI_ACLK);
      #1;
    end
    for (int c = 0; c < exp_len; c++) begin
      check_level("irq_4m", irq_4m, 1'b1);
      @(posedge M_AXI_ACLK);
      #1;
    end
    check_level("irq_4m", irq_4m, 1'b0);   // Must drop right after
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite write responder

  initial begin : axi_responder
    int   delay;
    logic pending;
    logic accepted;
    seed         = 32'hce11_2139;
    m_axi_wr_rsp = '0;
    pending      = 1'b0;
    accepted     = 1'b0;
    delay        = 0;
    forever begin
      @(posedge M_AXI_ACLK);
      #1;
      m_axi_wr_rsp = '0;
      if (accepted) begin
        m_axi_wr_rsp.bvalid = 1'b1;   // OKAY response
        accepted = 1'b0;
      end else if (m_axi_wr.awvalid && m_axi_wr.wvalid) begin
        if (!pending) begin
          pending = 1'b1;
          delay   = $unsigned($random(seed)) % 4;
        end
        if (delay == 0) begin
          m_axi_wr_rsp.awready = 1'b1;
          m_axi_wr_rsp.wready  = 1'b1;
          cmd_log.push_back(m_axi_wr);
          pending  = 1'b0;
          accepted = 1'b1;
        end else begin
          delay--;
        end
      end else begin
        pending = 1'b0;   // Aborted by a DMA interrupt
      end
    end
  end

  initial begin : watchdog
    wait (run_cycles != 0);
    repeat (run_cycles) @(posedge M_AXI_ACLK);
    $display("Timeout: the tests did not finish within %0d cycles", run_cycles);
    abort_run();
  end

  //////////////////////////////////////////////////////////////////////
  // Test driver

  initial begin : test_driver
    logic [31:0] op;
    logic [31:0] idx;
    logic [31:0] data;
    logic [31:0] expected;
    bus_rsp_t    rsp;
    bus_req = '0;
    irq_dma = 1'b0;
    cur_len = '0;
    for (int i = 0; i < 4 * MAX_LINES; i++) begin
      tv[i] = '0;
    end
    $readmemh("testbench/dma_init_tests.txt", tv);
    n_lines = 0;
    while ((n_lines < MAX_LINES) && (tv[4 * n_lines] != '0)) begin
      n_lines++;
    end
    if (n_lines == 0) begin
      $display("No test lines found in testbench/dma_init_tests.txt");
      abort_run();
    end
    run_cycles = n_lines * 2000 + 1000;

    wait (M_AXI_ARESETN === 1'b1);
    @(posedge M_AXI_ACLK);
    #1;
    check_level("str_lsr", str_lsr, 1'b0);
    check_level("irq_4m", irq_4m, 1'b0);
    check_level("m_axi_wr.awvalid", m_axi_wr.awvalid, 1'b0);
    check_level("m_axi_wr.wvalid", m_axi_wr.wvalid, 1'b0);
    check_level("m_axi_wr.bready", m_axi_wr.bready, 1'b1);

    for (int i = 0; i < n_lines; i++) begin
      op       = tv[4 * i];
      idx      = tv[4 * i + 1];
      data     = tv[4 * i + 2];
      expected = tv[4 * i + 3];
      case (op)
        OP_WRITE: begin
          bus_access(1'b0, idx, data, rsp);
          if (idx == 32'(`REG_LEN)) cur_len = data;
        end
        OP_READ: begin
          bus_access(1'b1, idx, 32'h0, rsp);
          check_bus_data(idx, rsp, expected);
        end
        OP_IRQ:   pulse_irq(data);
        OP_SEQ:   check_sequence(expected);
        OP_IRQ4M: count_irq4m(expected);
        default: begin
          $display("Unknown operation %h on test line %0d", op, i + 1);
          abort_run();
        end
      endcase
    end

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/dma_init_tests.txt ====
// Columns: op reg data expected, all hex
// op 1 write, 2 read, 3 irq_dma pulses, 4 check next sequence (cmd 4 data), 5 irq_4m length
2 03 00000000 00000000
2 04 00000000 00000000
1 00 00000040 00000000
2 00 00000000 00000040
1 02 00000100 00000000
2 02 00000000 00000100
2 09 00000000 00000000
1 01 10000000 00000000
1 01 20000000 00000000
1 01 30000000 00000000
2 01 00000000 10000000
2 03 00000000 00000002
4 00 00000000 10000000
2 04 00000000 00000000
1 00 00040000 00000000
3 00 00000003 00000000
2 04 00000000 00000003
3 00 00000001 00000000
5 00 00000000 00000040
2 01 00000000 20000000
2 04 00000000 00000000
2 03 00000000 00000001
1 00 00000040 00000000
3 00 00000002 00000000
2 04 00000000 00000002
4 00 00000000 20000200

// ==== vlog.f ====
+incdir+include
verilog/dma_init_pkg.sv
verilog/reg_bank.sv
verilog/addr_queue.sv
verilog/segment_tracker.sv
verilog/dma_programmer.sv
verilog/dma_init_top.sv
testbench/tb_clock.sv
testbench/tb_dma_init.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_dma_init
	@out="$$(./obj_dir/Vtb_dma_init)"; echo "$$out"; echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
